/* project.f */
common/rvPkg.sv
hw/fetch/fetchUnit.sv
hw/fetch/branchPredictor.sv
hw/decode/regFile.sv
hw/decode/decodeUnit.sv
hw/execute/executeUnit.sv
hw/rvCore.sv
sim/tbCore_assert.sv
sim/tbCore.sv

/* Bender.yml */
package:
  name: rvcore

sources:
  - files:
      - common/rvPkg.sv
      - hw/fetch/fetchUnit.sv
      - hw/fetch/branchPredictor.sv
      - hw/decode/regFile.sv
      - hw/decode/decodeUnit.sv
      - hw/execute/executeUnit.sv
      - hw/rvCore.sv
  - target: simulation
    files:
      - sim/tbCore_assert.sv
      - sim/tbCore.sv

/* sim/tbCore.sv */
// Core testbench with LFSR, program generator, ISA model, memories, store checks and watchdog
`timescale 1ns/10ps

module tbCore import rvPkg::*; ();

	localparam word_t resetPc = '0;
	localparam int numInstr = 200;
	localparam int lastIdx = numInstr - 1;	// Self-loop jal
	localparam int imemWords = 256;
	localparam int dmemWords = 64;
	localparam int clkPeriod = 4;
	localparam int tailCycles = 50;
	localparam int timeoutCycles = numInstr * 8 + tailCycles + 100;

	// Instruction classes of the generator
	localparam int kAlu = 0;
	localparam int kImm = 1;
	localparam int kLoad = 2;
	localparam int kStore = 3;
	localparam int kBranch = 4;
	localparam int kJal = 5;

	logic      clk;
	logic      rst_n;
	wordAddr_t iAddr;
	word_t     iData;
	logic      iStall;
	logic      dRead;
	logic      dWrite;
	wordAddr_t dAddr;
	word_t     dWdata;
	word_t     dRdata;
	logic      dStall;

	word_t imem [imemWords];
	word_t dmem [dmemWords];
	logic [31:0] lfsr = 32'h6455;

	// imm holds a word offset or word index outside the ALU classes
	int         kind [numInstr];
	logic [2:0] f3 [numInstr];
	logic       alt [numInstr];
	logic [4:0] rd [numInstr];
	logic [4:0] rs1 [numInstr];
	logic [4:0] rs2 [numInstr];
	word_t      imm [numInstr];

	word_t modelReg [32];
	word_t modelMem [dmemWords];
	int    expAddr [$];
	word_t expData [$];
	int    expCount = 0;
	int    storeCount = 0;

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	assign iData  = imem[iAddr[7:0]];
	assign dRdata = dmem[dAddr[5:0]];

	rvCore #(
		.resetPc(resetPc)
	) i_dut (
		.clk(clk), .rst_n(rst_n), .iAddr(iAddr), .iData(iData), .iStall(iStall),
		.dRead(dRead), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
		.dRdata(dRdata), .dStall(dStall)
	);

	bind rvCore tbCore_assert i_assert (
		.clk(clk), .rst_n(rst_n), .hold(hold), .iAddr(iAddr), .dRead(dRead),
		.dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata)
	);

	// ========================================
	// Helpers
	// ========================================
	function automatic word_t randBits(int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];	// x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t swapBytes(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	function automatic word_t encJal(logic [4:0] rdv, word_t off);
		return {off[20], off[10:1], off[11], off[19:12], rdv, opJal};
	endfunction

	function automatic word_t encode(int i);
		word_t off;
		off = imm[i] << 2;	// Words to bytes
		case (kind[i])
			kAlu:    return {1'b0, alt[i], 5'b0, rs2[i], rs1[i], f3[i], rd[i], opReg};
			kImm:    return {imm[i][11:0], rs1[i], f3[i], rd[i], opImm};
			kLoad:   return {off[11:0], 5'd0, 3'b010, rd[i], opLoad};
			kStore:  return {off[11:5], rs2[i], 5'd0, 3'b010, off[4:0], opStore};
			kBranch: return {off[12], off[10:5], rs2[i], rs1[i], f3[i], off[4:1], off[11],
				opBranch};
			default: return encJal(rd[i], off);
		endcase
	endfunction

	// RV32I result for funct3 and the funct7 bit 5 flag
	function automatic word_t aluModel(logic [2:0] fn, logic altOp, word_t a, word_t b);
		case (fn)
			3'd0: return altOp ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (altOp) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkEqual(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// ========================================
	// Program generator and ISA model
	// ========================================
	task automatic buildProgram();
		word_t pick;
		for (int i = 0; i < lastIdx; i++) begin
			pick   = randBits(4);
			rd[i]  = randBits(3);	// x0..x7 for dense dependencies
			rs1[i] = randBits(3);
			rs2[i] = randBits(3);
			f3[i]  = randBits(3);
			alt[i] = 1'b0;
			imm[i] = randBits(12);
			if (f3[i] == 3'd3) begin
				f3[i] = 3'd0;	// No unsigned compare
			end
			if (pick < 5) begin
				kind[i] = kAlu;
				if (f3[i] == 3'd0 || f3[i] == 3'd5) begin
					alt[i] = randBits(1);	// sub or sra
				end
			end else if (pick < 9) begin
				kind[i] = kImm;
				if (f3[i] == 3'd5) begin
					alt[i] = randBits(1);
				end
				if (f3[i] == 3'd1 || f3[i] == 3'd5) begin
					imm[i] = {alt[i], 5'b0, imm[i][4:0]};	// shamt with funct7
				end
			end else if (pick < 13) begin
				kind[i] = (pick < 11) ? kLoad : kStore;
				imm[i]  = imm[i] % dmemWords;
			end else begin
				kind[i] = (pick < 15) ? kBranch : kJal;
				f3[i]   = {2'b0, f3[i][0]};	// beq or bne
				imm[i]  = imm[i][1:0] + 1;	// Forward only
				if (i + imm[i] > lastIdx) begin
					imm[i] = lastIdx - i;
				end
			end
		end
		kind[lastIdx] = kJal;
		rd[lastIdx]   = 5'd0;
		imm[lastIdx]  = '0;
	endtask

	task automatic runModel();
		int    pc;
		word_t a;
		word_t b;
		logic  taken;
		pc = resetPc >> 2;
		for (int r = 0; r < 32; r++) begin
			modelReg[r] = '0;
		end
		while (pc != lastIdx) begin
			a = modelReg[rs1[pc]];
			b = modelReg[rs2[pc]];
			case (kind[pc])
				kAlu:  modelReg[rd[pc]] = aluModel(f3[pc], alt[pc], a, b);
				kImm:  modelReg[rd[pc]] = aluModel(f3[pc], alt[pc], a,
					{{20{imm[pc][11]}}, imm[pc][11:0]});
				kLoad: modelReg[rd[pc]] = modelMem[imm[pc]];
				kStore: begin
					modelMem[imm[pc]] = b;
					expAddr.push_back(imm[pc]);
					expData.push_back(b);
				end
				kJal:  modelReg[rd[pc]] = (pc + 1) * 4;	// Link
				default: ;
			endcase
			modelReg[0] = '0;
			taken = (kind[pc] == kBranch) && ((a == b) ^ f3[pc][0]);
			pc    = (taken || kind[pc] == kJal) ? pc + imm[pc] : pc + 1;
		end
	endtask

	task automatic driveStalls();
		forever begin
			@(negedge clk);
			iStall = (randBits(2) == 0);	// About one cycle in four
			dStall = (randBits(2) == 0);
		end
	endtask

	// ========================================
	// Data memory writes and store checks
	// ========================================
	always @(posedge clk) begin
		if (rst_n && dWrite && !(iStall || dStall)) begin
			dmem[dAddr[5:0]] <= dWdata;
			if (storeCount >= expCount) begin
				$display("Store to word %0h seen after the last expected store", dAddr);
				$display("sim failed");
				$fatal(1, "Extra store");
			end else begin
				checkEqual($sformatf("store%0d addr", storeCount), expAddr[storeCount],
					{2'b0, dAddr});
				checkEqual($sformatf("store%0d data", storeCount),
					swapBytes(expData[storeCount]), dWdata);
				storeCount++;
			end
		end
	end

	initial begin
		rst_n  = 1'b0;
		iStall = 1'b0;
		dStall = 1'b0;
		for (int a = 0; a < dmemWords; a++) begin
			dmem[a]     = randBits(32);
			modelMem[a] = swapBytes(dmem[a]);	// Memory words are little-endian
		end
		buildProgram();
		for (int a = 0; a < imemWords; a++) begin
			if (a < numInstr) begin
				imem[a] = swapBytes(encode(a));
			end else begin
				imem[a] = swapBytes(encJal(5'd0, word_t'((lastIdx - a) * 4)));	// Back to the loop
			end
		end
		runModel();
		expCount = expAddr.size();

		@(negedge clk);
		checkEqual("reset dRead", '0, {31'b0, dRead});
		checkEqual("reset dWrite", '0, {31'b0, dWrite});
		@(negedge clk);
		checkEqual("reset iAddr", resetPc >> 2, {2'b0, iAddr});
		rst_n = 1'b1;

		fork
			driveStalls();
		join_none

		wait (storeCount == expCount);
		repeat (tailCycles) @(posedge clk);	// No late store may follow
		if (i_dut.i_assert.failCount == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "Bound assertions failed");
		end
	end

	// Bound assertion failures end the run at once
	initial begin
		wait (i_dut.i_assert.failCount != 0);
		$display("A bound assertion on the core ports failed");
		$display("sim failed");
		$fatal(1, "Assertion failure");
	end

	// Watchdog
	initial begin
		#(timeoutCycles * clkPeriod);
		$display("Timeout, only %0d of %0d stores were seen", storeCount, expCount);
		$display("sim failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

/* sim/tbCore_assert.sv */
// Bound assertions on the core memory ports during reset, hold and stores
`timescale 1ns/10ps

module tbCore_assert import rvPkg::*; (
	input logic      clk,
	input logic      rst_n,
	input logic      hold,
	input wordAddr_t iAddr,
	input logic      dRead,
	input logic      dWrite,
	input wordAddr_t dAddr,
	input word_t     dWdata
);

	int failCount = 0;	// Read by the testbench at the end

	// Synchronous reset clears the strobes by the next edge
	noAccessInReset: assert property (@(posedge clk) !rst_n |=> !dRead && !dWrite)
		else begin
			$error("Data port strobe high during reset");
			failCount++;
		end

	readWriteExclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dRead && dWrite))
		else begin
			$error("dRead and dWrite both high");
			failCount++;
		end

	fetchHeld: assert property (@(posedge clk) disable iff (!rst_n) hold |=> $stable(iAddr))
		else begin
			$error("iAddr moved after a held cycle");
			failCount++;
		end

	// Pending store waits unchanged
	storeHeld: assert property (@(posedge clk) disable iff (!rst_n)
		dWrite && hold |=> $stable(dAddr) && $stable(dWdata))
		else begin
			$error("Store address or data changed under hold");
			failCount++;
		end

endmodule

/* hw/rvCore.sv */
// Pipelined core top level with stage instances, interconnect and global hold
`timescale 1ns/10ps

module rvCore import rvPkg::*; #(
	parameter word_t resetPc = '0
) (
	input  logic      clk,
	input  logic      rst_n,
	output wordAddr_t iAddr,
	input  word_t     iData,
	input  logic      iStall,
	output logic      dRead,
	output logic      dWrite,
	output wordAddr_t dAddr,
	output word_t     dWdata,
	input  word_t     dRdata,
	input  logic      dStall
);

	logic hold;

	// IF and IF/ID
	instrWord_t ifInstr;
	word_t      ifPc;
	instrWord_t idInstr;
	word_t      idPc;
	word_t      idPcPlus4;
	logic       idPredTaken;
	word_t      idPredTarget;
	logic       predTaken;
	word_t      predTarget;

	// ID side
	regAddr_t rs1Addr;
	regAddr_t rs2Addr;
	word_t    rs1Data;
	word_t    rs2Data;
	logic     hazardStall;
	logic     redirect;
	word_t    redirectPc;
	logic     branchValid;
	logic     branchTaken;

	// ID/EX
	word_t    exRs1Data;
	word_t    exRs2Data;
	word_t    exImm;
	regAddr_t exRs1;
	regAddr_t exRs2;
	regAddr_t exRd;
	aluOp_t   exAluOp;
	logic     exAluSrc;
	logic     exMemRead;
	logic     exMemWrite;
	logic     exMemToReg;
	logic     exRegWrite;
	logic     exIsJump;
	word_t    exPcPlus4;

	// MEM and WB results
	regAddr_t meRd;
	logic     meRegWrite;
	word_t    meResult;
	regAddr_t wbRd;
	logic     wbRegWrite;
	word_t    wbData;

	assign hold = iStall | dStall;	// Either port freezes everything

	fetchUnit #(
		.resetPc(resetPc)
	) i_fetch (
		.clk(clk), .rst_n(rst_n), .hold(hold), .hazardStall(hazardStall),
		.redirect(redirect), .redirectPc(redirectPc), .iData(iData),
		.predTaken(predTaken), .predTarget(predTarget), .iAddr(iAddr),
		.ifInstr(ifInstr), .ifPc(ifPc), .idInstr(idInstr), .idPc(idPc),
		.idPcPlus4(idPcPlus4), .idPredTaken(idPredTaken), .idPredTarget(idPredTarget)
	);

	branchPredictor i_pred (
		.clk(clk), .rst_n(rst_n), .hold(hold), .ifInstr(ifInstr), .ifPc(ifPc),
		.branchValid(branchValid), .branchTaken(branchTaken),
		.predTaken(predTaken), .predTarget(predTarget)
	);

	decodeUnit i_decode (
		.clk(clk), .rst_n(rst_n), .hold(hold), .idInstr(idInstr), .idPc(idPc),
		.idPcPlus4(idPcPlus4), .idPredTaken(idPredTaken), .idPredTarget(idPredTarget),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .meRd(meRd), .meRegWrite(meRegWrite),
		.meResult(meResult), .wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .hazardStall(hazardStall),
		.redirect(redirect), .redirectPc(redirectPc), .branchValid(branchValid),
		.branchTaken(branchTaken), .exRs1Data(exRs1Data), .exRs2Data(exRs2Data),
		.exImm(exImm), .exRs1(exRs1), .exRs2(exRs2), .exRd(exRd), .exAluOp(exAluOp),
		.exAluSrc(exAluSrc), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
		.exMemToReg(exMemToReg), .exRegWrite(exRegWrite), .exIsJump(exIsJump),
		.exPcPlus4(exPcPlus4)
	);

	regFile i_regs (
		.clk(clk), .rst_n(rst_n), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	executeUnit i_execute (
		.clk(clk), .rst_n(rst_n), .hold(hold), .exRs1Data(exRs1Data),
		.exRs2Data(exRs2Data), .exImm(exImm), .exRs1(exRs1), .exRs2(exRs2),
		.exRd(exRd), .exAluOp(exAluOp), .exAluSrc(exAluSrc), .exMemRead(exMemRead),
		.exMemWrite(exMemWrite), .exMemToReg(exMemToReg), .exRegWrite(exRegWrite),
		.exIsJump(exIsJump), .exPcPlus4(exPcPlus4), .dRdata(dRdata),
		.dRead(dRead), .dWrite(dWrite), .dAddr(dAddr), .dWdata(dWdata),
		.meRd(meRd), .meRegWrite(meRegWrite), .meResult(meResult),
		.wbRd(wbRd), .wbRegWrite(wbRegWrite), .wbData(wbData)
	);

endmodule

/* hw/execute/executeUnit.sv */
// Execute, memory and write-back stages with EX forwarding, ALU, EX/MEM and MEM/WB registers
`timescale 1ns/10ps

module executeUnit import rvPkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      hold,
	input  word_t     exRs1Data,
	input  word_t     exRs2Data,
	input  word_t     exImm,
	input  regAddr_t  exRs1,
	input  regAddr_t  exRs2,
	input  regAddr_t  exRd,
	input  aluOp_t    exAluOp,
	input  logic      exAluSrc,
	input  logic      exMemRead,
	input  logic      exMemWrite,
	input  logic      exMemToReg,
	input  logic      exRegWrite,
	input  logic      exIsJump,
	input  word_t     exPcPlus4,
	input  word_t     dRdata,
	output logic      dRead,
	output logic      dWrite,
	output wordAddr_t dAddr,
	output word_t     dWdata,
	output regAddr_t  meRd,
	output logic      meRegWrite,
	output word_t     meResult,
	output regAddr_t  wbRd,
	output logic      wbRegWrite,
	output word_t     wbData
);

	word_t opA;
	word_t opB;
	word_t aluB;
	word_t aluOut;
	word_t meAlu;
	word_t mePcPlus4;
	logic  meMemToReg;
	logic  meIsJump;
	word_t loadData;
	word_t wbAlu;
	word_t wbLoad;
	word_t wbPcPlus4;
	logic  wbMemToReg;
	logic  wbIsJump;

	function automatic word_t byteSwap(word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Link, load or ALU value of one stage
	function automatic word_t selResult(logic isJump, logic memToReg, word_t pcPlus4,
			word_t load, word_t alu);
		if (isJump) begin
			return pcPlus4;
		end
		return memToReg ? load : alu;
	endfunction

	function automatic word_t forward(regAddr_t src, word_t regVal);
		if (meRegWrite && meRd != '0 && meRd == src) begin
			return meResult;
		end else if (wbRegWrite && wbRd != '0 && wbRd == src) begin
			return wbData;
		end
		return regVal;
	endfunction

	// ========================================
	// EX stage
	// ========================================
	always_comb begin
		opA = forward(exRs1, exRs1Data);
		opB = forward(exRs2, exRs2Data);	// Also the store data
	end

	assign aluB = exAluSrc ? exImm : opB;

	always_comb begin
		case (exAluOp)
			aluAdd:  aluOut = opA + aluB;
			aluSub:  aluOut = opA - aluB;
			aluSll:  aluOut = opA << aluB[4:0];
			aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(aluB)};
			aluXor:  aluOut = opA ^ aluB;
			aluSrl:  aluOut = opA >> aluB[4:0];
			aluSra:  aluOut = $signed(opA) >>> aluB[4:0];
			aluOr:   aluOut = opA | aluB;
			aluAnd:  aluOut = opA & aluB;
			default: aluOut = '0;
		endcase
	end

	// ========================================
	// EX/MEM register and data port
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			meRd       <= '0;
			meRegWrite <= 1'b0;
			dRead      <= 1'b0;
			dWrite     <= 1'b0;
			meMemToReg <= 1'b0;
			meIsJump   <= 1'b0;
		end else if (!hold) begin
			meRd       <= exRd;
			meRegWrite <= exRegWrite;
			dRead      <= exMemRead;
			dWrite     <= exMemWrite;
			meMemToReg <= exMemToReg;
			meIsJump   <= exIsJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			meAlu     <= aluOut;
			dWdata    <= byteSwap(opB);	// Little-endian store
			mePcPlus4 <= exPcPlus4;
		end
	end

	assign dAddr    = meAlu[xlen-1:2];
	assign loadData = byteSwap(dRdata);
	assign meResult = selResult(meIsJump, meMemToReg, mePcPlus4, loadData, meAlu);

	// ========================================
	// MEM/WB register and write-back
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbRd       <= '0;
			wbRegWrite <= 1'b0;
			wbMemToReg <= 1'b0;
			wbIsJump   <= 1'b0;
		end else if (!hold) begin
			wbRd       <= meRd;
			wbRegWrite <= meRegWrite;
			wbMemToReg <= meMemToReg;
			wbIsJump   <= meIsJump;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			wbAlu     <= meAlu;
			wbLoad    <= loadData;
			wbPcPlus4 <= mePcPlus4;
		end
	end

	assign wbData = selResult(wbIsJump, wbMemToReg, wbPcPlus4, wbLoad, wbAlu);

endmodule

/* hw/decode/decodeUnit.sv */
// Decode stage with control decode, immediates, branch resolution, hazards and ID/EX register
`timescale 1ns/10ps

module decodeUnit import rvPkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hold,
	input  instrWord_t idInstr,
	input  word_t      idPc,
	input  word_t      idPcPlus4,
	input  logic       idPredTaken,
	input  word_t      idPredTarget,
	input  word_t      rs1Data,
	input  word_t      rs2Data,
	input  regAddr_t   meRd,
	input  logic       meRegWrite,
	input  word_t      meResult,
	input  regAddr_t   wbRd,
	input  logic       wbRegWrite,
	input  word_t      wbData,
	output regAddr_t   rs1Addr,
	output regAddr_t   rs2Addr,
	output logic       hazardStall,
	output logic       redirect,
	output word_t      redirectPc,
	output logic       branchValid,
	output logic       branchTaken,
	output word_t      exRs1Data,
	output word_t      exRs2Data,
	output word_t      exImm,
	output regAddr_t   exRs1,
	output regAddr_t   exRs2,
	output regAddr_t   exRd,
	output aluOp_t     exAluOp,
	output logic       exAluSrc,
	output logic       exMemRead,
	output logic       exMemWrite,
	output logic       exMemToReg,
	output logic       exRegWrite,
	output logic       exIsJump,
	output word_t      exPcPlus4
);

	logic [6:0] opcode;
	logic       isLoad;
	logic       isStore;
	logic       isBranch;
	logic       isImm;
	logic       isReg;
	logic       isJal;
	logic       isShiftImm;
	logic       regWrite;
	aluOp_t     aluOp;
	word_t      iImm;
	word_t      sImm;
	word_t      jImm;
	word_t      imm;
	word_t      fwdRs1;
	word_t      fwdRs2;
	logic       taken;
	logic       mispredict;
	logic       exHit;

	// Newest producer wins
	function automatic word_t forward(regAddr_t src, word_t regVal);
		if (meRegWrite && meRd != '0 && meRd == src) begin
			return meResult;
		end else if (wbRegWrite && wbRd != '0 && wbRd == src) begin
			return wbData;
		end
		return regVal;
	endfunction

	// ========================================
	// Main and ALU control
	// ========================================
	assign opcode     = idInstr.rFmt.opcode;
	assign rs1Addr    = idInstr.rFmt.rs1;
	assign rs2Addr    = idInstr.rFmt.rs2;
	assign isLoad     = (opcode == opLoad);
	assign isStore    = (opcode == opStore);
	assign isBranch   = (opcode == opBranch);
	assign isImm      = (opcode == opImm);
	assign isReg      = (opcode == opReg);
	assign isJal      = (opcode == opJal);
	assign isShiftImm = isImm && (idInstr.iFmt.funct3 == 3'b101);
	assign regWrite   = isReg | isImm | isLoad | isJal;

	always_comb begin
		if (isReg || isShiftImm) begin
			aluOp = aluOp_t'({idInstr.rFmt.funct7[5], idInstr.rFmt.funct3});
		end else if (isImm) begin
			aluOp = aluOp_t'({1'b0, idInstr.iFmt.funct3});
		end else begin
			aluOp = aluAdd;	// Address and link paths
		end
	end

	// Immediates
	assign iImm = {{20{idInstr.iFmt.imm[11]}}, idInstr.iFmt.imm};
	assign sImm = {{20{idInstr.sFmt.immHi[6]}}, idInstr.sFmt.immHi, idInstr.sFmt.immLo};
	assign jImm = {{11{idInstr.jFmt.imm20}}, idInstr.jFmt.imm20, idInstr.jFmt.imm19_12,
		idInstr.jFmt.imm11, idInstr.jFmt.imm10_1, 1'b0};

	always_comb begin
		if (isStore) begin
			imm = sImm;
		end else if (isShiftImm) begin
			imm = {27'b0, idInstr.iFmt.imm[4:0]};	// shamt, zero-extended
		end else begin
			imm = iImm;
		end
	end

	// ========================================
	// Branch resolution and hazards
	// ========================================
	always_comb begin
		fwdRs1 = forward(rs1Addr, rs1Data);
		fwdRs2 = forward(rs2Addr, rs2Data);
	end

	// funct3[0] separates bne from beq
	assign taken      = isBranch && ((fwdRs1 == fwdRs2) ^ idInstr.bFmt.funct3[0]);
	assign mispredict = isBranch && (taken != idPredTaken);

	// EX producer not yet forwardable
	assign exHit = exRegWrite && exRd != '0 && (exRd == rs1Addr || exRd == rs2Addr);
	assign hazardStall = exHit && (exMemRead || isBranch);

	assign redirect    = !hazardStall && (isJal || mispredict);
	assign branchValid = isBranch && !hazardStall;
	assign branchTaken = taken;

	always_comb begin
		if (isJal) begin
			redirectPc = idPc + jImm;
		end else if (taken) begin
			redirectPc = idPredTarget;	// Was guessed not taken
		end else begin
			redirectPc = idPcPlus4;
		end
	end

	// ========================================
	// ID/EX register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n || (!hold && hazardStall)) begin
			exRs1      <= '0;	// Bubble
			exRs2      <= '0;
			exRd       <= '0;
			exAluOp    <= aluAdd;
			exAluSrc   <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exMemToReg <= 1'b0;
			exRegWrite <= 1'b0;
			exIsJump   <= 1'b0;
		end else if (!hold) begin
			exRs1      <= rs1Addr;
			exRs2      <= rs2Addr;
			exRd       <= idInstr.rFmt.rd;
			exAluOp    <= aluOp;
			exAluSrc   <= isImm | isLoad | isStore;
			exMemRead  <= isLoad;
			exMemWrite <= isStore;
			exMemToReg <= isLoad;
			exRegWrite <= regWrite;
			exIsJump   <= isJal;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			exRs1Data <= fwdRs1;
			exRs2Data <= fwdRs2;
			exImm     <= imm;
			exPcPlus4 <= idPcPlus4;
		end
	end

endmodule

/* hw/decode/regFile.sv */
// Register file, 31 writable words with write-back pass-through on both read ports
`timescale 1ns/10ps

module regFile import rvPkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  regAddr_t rs1Addr,
	input  regAddr_t rs2Addr,
	input  regAddr_t wbRd,
	input  logic     wbRegWrite,
	input  word_t    wbData,
	output word_t    rs1Data,
	output word_t    rs2Data
);

	word_t regs [1:31];

	function automatic word_t readPort(regAddr_t addr);
		if (addr == '0) begin
			return '0;	// x0
		end else if (wbRegWrite && wbRd == addr) begin
			return wbData;	// Same-cycle write-back
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1Data = readPort(rs1Addr);
		rs2Data = readPort(rs2Addr);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbRegWrite && wbRd != '0) begin
			regs[wbRd] <= wbData;
		end
	end

endmodule

/* hw/fetch/branchPredictor.sv */
// One-bit branch predictor FSM with predicted-target adder for the fetched branch
`timescale 1ns/10ps

module branchPredictor import rvPkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hold,
	input  instrWord_t ifInstr,
	input  word_t      ifPc,
	input  logic       branchValid,
	input  logic       branchTaken,
	output logic       predTaken,
	output word_t      predTarget
);

	localparam logic stTaken    = 1'b0;
	localparam logic stNotTaken = 1'b1;

	logic  state;
	logic  stateNext;
	word_t bImm;

	// Last resolved outcome decides the next guess
	always_comb begin
		stateNext = state;
		case (state)
			stTaken: begin
				if (branchValid && !branchTaken) begin
					stateNext = stNotTaken;
				end
			end
			stNotTaken: begin
				if (branchValid && branchTaken) begin
					stateNext = stTaken;
				end
			end
			default: stateNext = stTaken;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= stTaken;
		end else if (!hold) begin
			state <= stateNext;
		end
	end

	assign predTaken = (state == stTaken);

	// B-type immediate of the word in IF
	assign bImm = {{20{ifInstr.bFmt.imm12}}, ifInstr.bFmt.imm11,
		ifInstr.bFmt.imm10_5, ifInstr.bFmt.imm4_1, 1'b0};
	assign predTarget = ifPc + bImm;

endmodule

/* hw/fetch/fetchUnit.sv */
// Fetch stage with PC register, next-PC select, instruction byte swap and IF/ID register
`timescale 1ns/10ps

module fetchUnit import rvPkg::*; #(
	parameter word_t resetPc = '0
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       hold,
	input  logic       hazardStall,
	input  logic       redirect,
	input  word_t      redirectPc,
	input  word_t      iData,
	input  logic       predTaken,
	input  word_t      predTarget,
	output wordAddr_t  iAddr,
	output instrWord_t ifInstr,
	output word_t      ifPc,
	output instrWord_t idInstr,
	output word_t      idPc,
	output word_t      idPcPlus4,
	output logic       idPredTaken,
	output word_t      idPredTarget
);

	word_t pc;
	word_t pcPlus4;
	word_t nextPc;
	logic  freeze;

	assign freeze  = hold | hazardStall;
	assign pcPlus4 = pc + 32'd4;
	assign iAddr   = pc[xlen-1:2];
	assign ifPc    = pc;

	// Memory holds little-endian words
	assign ifInstr = {iData[7:0], iData[15:8], iData[23:16], iData[31:24]};

	// ========================================
	// Next PC
	// ========================================
	always_comb begin
		if (freeze) begin
			nextPc = pc;
		end else if (redirect) begin
			nextPc = redirectPc;	// Jal or branch repair from ID
		end else if (ifInstr.bFmt.opcode == opBranch && predTaken) begin
			nextPc = predTarget;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= resetPc;
		end else begin
			pc <= nextPc;
		end
	end

	// ========================================
	// IF/ID register
	// ========================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			idInstr     <= nopInstr;
			idPredTaken <= 1'b1;
		end else if (!freeze) begin
			if (redirect) begin
				idInstr     <= nopInstr;	// Kill the wrong-path fetch
				idPredTaken <= 1'b1;
			end else begin
				idInstr     <= ifInstr;
				idPredTaken <= predTaken;
			end
		end
	end

	// Payload follows the same freeze
	always_ff @(posedge clk) begin
		if (!freeze) begin
			idPc         <= pc;
			idPcPlus4    <= pcPlus4;
			idPredTarget <= predTarget;
		end
	end

endmodule

/* common/rvPkg.sv */
// Core package with widths, word types, opcodes, ALU operations and instruction formats
package rvPkg;

	localparam int xlen = 32;
	localparam int regAddrBits = 5;

	typedef logic [xlen-1:0] word_t;
	typedef logic [regAddrBits-1:0] regAddr_t;
	typedef logic [xlen-3:0] wordAddr_t;	// Byte address without bits 1:0

	// ========================================
	// ALU operations
	// ========================================
	// Bit 3 mirrors funct7[5] for R-type and srli/srai
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111,
		aluSub = 4'b1000,
		aluSra = 4'b1101
	} aluOp_t;

	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opJal    = 7'b1101111;

	localparam word_t nopInstr = 32'h0000_0013;	// addi x0, x0, 0

	// ========================================
	// Instruction formats
	// ========================================
	typedef struct packed {
		logic [6:0] funct7;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		regAddr_t   rd;
		logic [6:0] opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm;
		regAddr_t    rs1;
		logic [2:0]  funct3;
		regAddr_t    rd;
		logic [6:0]  opcode;
	} iFmt_t;

	typedef struct packed {
		logic [6:0] immHi;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		regAddr_t   rs2;
		regAddr_t   rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} bFmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		regAddr_t   rd;
		logic [6:0] opcode;
	} jFmt_t;

	// Same 32 bits seen through each format
	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
		sFmt_t sFmt;
		bFmt_t bFmt;
		jFmt_t jFmt;
	} instrWord_t;

endpackage
